/* include/dvs_params.svh */
`ifndef DVS_PARAMS_SVH
`define DVS_PARAMS_SVH

// Pixels per side of the sensor array
`define ARRAY_DIM 8

// Children per side of one arbiter group, 2x2
`define GROUP_DIM 2

// Tree depth, leaf to root
`define LEVELS 3

// Row or column address, one bit per level
`define ADDR_W 3

// Free-running timestamp
`define TS_W 16

// Polarity request bits per pixel, bit 0 ON, bit 1 OFF
`define POL_W 2

`endif

/* hw/arb_pkg.sv */
`default_nettype none

`include "dvs_params.svh"

package arb_pkg;

    // Flat index inside a 2x2 group, row * 2 + col
    typedef logic [$clog2(`GROUP_DIM * `GROUP_DIM)-1:0] child_idx_t;

    // Round-robin pointer, first child of the last lock session
    typedef child_idx_t rr_ptr_t;

    // State of one group arbiter
    typedef struct packed {
        logic       locked;  // Group owns a child until drained
        child_idx_t chosen;  // Child currently served
    } group_state_t;

    // Row or column of a pixel, root bit on top
    typedef logic [`ADDR_W-1:0] coord_t;

endpackage

`default_nettype wire

/* hw/aer_pkg.sv */
`default_nettype none

`include "dvs_params.svh"

package aer_pkg;

    // Event polarity carried in the packet
    typedef enum logic {
        OFF = 1'b0,  // Brightness decrease
        ON  = 1'b1   // Brightness increase
    } polarity_e;

    // Address-event word, timestamp in the top bits
    typedef struct packed {
        logic [`TS_W-1:0]   timestamp;  // Counter value in the grant cycle
        logic [`ADDR_W-1:0] x;          // Pixel row
        logic [`ADDR_W-1:0] y;          // Pixel column
        polarity_e          polarity;
    } aer_event_t;

endpackage

`default_nettype wire

/* hw/arb_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Link between two adjacent arbiter levels
// N is the side of the child grid
interface arb_if #(
    parameter int N = 2
);
    logic [N-1:0][N-1:0] req;   // From the child grid
    logic [N-1:0][N-1:0] gnt;   // Back down to the child grid
    logic                grp_release; // Some child group just unlocked
    logic                active;      // Some child group holds a lock

    // Upper level side
    modport parent (
        input  req,
        input  grp_release,
        input  active,
        output gnt
    );

    // Lower level side
    modport child (
        output req,
        output grp_release,
        output active,
        input  gnt
    );

endinterface

`default_nettype wire

/* hw/group_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvs_params.svh"

module group_arbiter
    import arb_pkg::*;
(
    input  wire logic                                  clk_i,
    input  wire logic                                  reset_i,
    input  wire logic [`GROUP_DIM*`GROUP_DIM-1:0]      req_i,
    input  wire logic                                  parent_gnt_i,
    output logic      [`GROUP_DIM*`GROUP_DIM-1:0]      gnt_o,
    output child_idx_t                                 chosen_o,
    output logic                                       locked_o,
    output logic                                       grp_release_o
);

    localparam int KIDS = `GROUP_DIM * `GROUP_DIM;

    group_state_t state_q;
    rr_ptr_t      rr_ptr_q;  // Where the last session started
    logic         any_req;
    child_idx_t   pick_idle; // Next session start
    child_idx_t   pick_busy; // Next child inside a session

    // First requesting child after base, wrapping; base itself last
    function automatic child_idx_t next_child(
        input logic [KIDS-1:0] req,
        input child_idx_t      base
    );
        child_idx_t idx;
        child_idx_t pick;
        pick = base;
        for (int k = KIDS - 1; k >= 1; k--)
        begin
            idx = base + child_idx_t'(k);  // Wraps inside the group
            if (req[idx])
                pick = idx;                // Smaller offset wins
        end
        return pick;
    endfunction

    assign any_req   = |req_i;
    assign pick_idle = next_child(req_i, rr_ptr_q);
    assign pick_busy = next_child(req_i, state_q.chosen);

    // Lock as soon as a child requests, so a whole path settles on one edge
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q       <= '0;
            rr_ptr_q      <= '0;
            grp_release_o <= 1'b0;
        end
        else
        begin
            grp_release_o <= 1'b0;  // Single-cycle pulse
            if (!state_q.locked)
            begin
                if (any_req)
                begin
                    state_q.locked <= 1'b1;
                    state_q.chosen <= pick_idle;
                    rr_ptr_q       <= pick_idle;  // Next session starts after this one
                end
            end
            else if (!req_i[state_q.chosen])
            begin
                // Served child finished
                if (any_req)
                    state_q.chosen <= pick_busy;
                else
                begin
                    state_q       <= '0;    // Drained, unlock
                    grp_release_o <= 1'b1;
                end
            end
        end
    end

    // One-hot grant, only along a granted path and while the child requests
    assign gnt_o = req_i
                 & ({{(KIDS-1){1'b0}}, 1'b1} << state_q.chosen)
                 & {KIDS{state_q.locked & parent_gnt_i}};

    assign chosen_o = state_q.chosen;
    assign locked_o = state_q.locked;

endmodule

`default_nettype wire

/* hw/arbiter_level.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvs_params.svh"

module arbiter_level
    import arb_pkg::*;
#(
    parameter int N = 8  // Child grid side
)
(
    input  wire logic clk_i,
    input  wire logic reset_i,
    arb_if.child      down,     // Toward the parent level
    arb_if.parent     up,       // Toward the child grid
    output logic      x_bits_o, // Row bit of the granted group
    output logic      y_bits_o  // Column bit of the granted group
);

    localparam int G    = N / `GROUP_DIM;           // Groups per side
    localparam int KIDS = `GROUP_DIM * `GROUP_DIM;

    logic       [G-1:0][G-1:0] locked_grp;
    logic       [G-1:0][G-1:0] release_grp;
    child_idx_t [G-1:0][G-1:0] chosen_grp;
    logic                      child_busy;

    // Served child group still draining below, no release seen yet
    assign child_busy = up.active & ~up.grp_release;

    for (genvar gi = 0; gi < G; gi++)
    begin : g_row
        for (genvar gj = 0; gj < G; gj++)
        begin : g_col
            logic [KIDS-1:0] raw_req;  // Block requests as seen
            logic [KIDS-1:0] hold;     // Keeps the served child until it releases
            logic [KIDS-1:0] eff_req;
            logic [KIDS-1:0] blk_gnt;

            for (genvar r = 0; r < `GROUP_DIM; r++)
            begin : g_r
                for (genvar c = 0; c < `GROUP_DIM; c++)
                begin : g_c
                    assign raw_req[r*`GROUP_DIM+c] = up.req[gi*`GROUP_DIM+r][gj*`GROUP_DIM+c];
                    assign up.gnt[gi*`GROUP_DIM+r][gj*`GROUP_DIM+c] = blk_gnt[r*`GROUP_DIM+c];
                end
            end

            assign hold    = ({{(KIDS-1){1'b0}}, 1'b1} << chosen_grp[gi][gj])
                           & {KIDS{locked_grp[gi][gj] & child_busy}};
            assign eff_req = raw_req | hold;

            group_arbiter u_group (
                .clk_i         (clk_i),
                .reset_i       (reset_i),
                .req_i         (eff_req),
                .parent_gnt_i  (down.gnt[gi][gj]),
                .gnt_o         (blk_gnt),
                .chosen_o      (chosen_grp[gi][gj]),
                .locked_o      (locked_grp[gi][gj]),
                .grp_release_o (release_grp[gi][gj])
            );

            assign down.req[gi][gj] = |raw_req;  // Block request upward
        end
    end

    assign down.active      = |locked_grp;
    assign down.grp_release = |release_grp;

    // Address bit from whichever group the parent grants
    always_comb
    begin
        x_bits_o = 1'b0;
        y_bits_o = 1'b0;
        for (int i = 0; i < G; i++)
        begin
            for (int j = 0; j < G; j++)
            begin
                x_bits_o = x_bits_o | (down.gnt[i][j] & chosen_grp[i][j][1]);  // Row half
                y_bits_o = y_bits_o | (down.gnt[i][j] & chosen_grp[i][j][0]);  // Col half
            end
        end
    end

endmodule

`default_nettype wire

/* hw/aer_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvs_params.svh"

module aer_encoder
    import arb_pkg::*;
    import aer_pkg::*;
(
    input  wire logic                                  clk_i,
    input  wire logic                                  reset_i,
    input  wire logic [`ARRAY_DIM-1:0][`ARRAY_DIM-1:0] gnt_i,
    input  wire coord_t                                x_i,
    input  wire coord_t                                y_i,
    input  wire logic [`POL_W-1:0]                     pol_req_i,
    output logic                                       event_valid_o,
    output aer_event_t                                 data_out_o
);

    logic [`TS_W-1:0]                  ts_q;   // Wall clock
    logic [`ARRAY_DIM-1:0][`ARRAY_DIM-1:0] gnt_q;  // Last cycle's grant grid
    logic                              new_gnt;
    polarity_e                         pol;
    aer_event_t                        pkt;

    // New grant: grid changed to a nonzero value on a polarized pixel
    assign new_gnt = (gnt_i != gnt_q) && (|gnt_i) && (|pol_req_i);

    // ON wins when both bits are set
    assign pol = pol_req_i[0] ? ON : OFF;

    always_comb
    begin
        pkt.timestamp = ts_q;  // Value in the grant cycle
        pkt.x         = x_i;
        pkt.y         = y_i;
        pkt.polarity  = pol;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ts_q          <= '0;
            gnt_q         <= '0;
            event_valid_o <= 1'b0;
        end
        else
        begin
            ts_q          <= ts_q + 1'b1;  // Free-running, wraps
            gnt_q         <= gnt_i;
            event_valid_o <= new_gnt;      // One cycle per grant
        end
    end

    // Event word held until the next grant
    always_ff @(posedge clk_i)
    begin
        if (new_gnt)
            data_out_o <= pkt;
    end

endmodule

`default_nettype wire

/* hw/pixel_hierarchy.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvs_params.svh"

module pixel_hierarchy
    import arb_pkg::*;
    import aer_pkg::*;
(
    input  wire logic                                               clk_i,
    input  wire logic                                               reset_i,
    input  wire logic [`ARRAY_DIM-1:0][`ARRAY_DIM-1:0][`POL_W-1:0] set_i,
    output logic      [`ARRAY_DIM-1:0][`ARRAY_DIM-1:0]             gnt_o,
    output logic                                                    grp_release_o,
    output logic                                                    event_valid_o,
    output logic      [$bits(aer_event_t)-1:0]                     data_out_o
);

    localparam int L1_DIM = `ARRAY_DIM / `GROUP_DIM;  // Leaf groups per side
    localparam int L2_DIM = L1_DIM / `GROUP_DIM;      // Mid groups per side

    logic [`LEVELS-1:0] x_bits;  // Index 0 from the leaves
    logic [`LEVELS-1:0] y_bits;
    coord_t             x_addr;
    coord_t             y_addr;
    logic [`POL_W-1:0]  pol_req;
    aer_event_t         event_word;

    arb_if #(.N(`ARRAY_DIM)) pix_if ();   // Pixels to leaf level
    arb_if #(.N(L1_DIM))     l0_if ();    // Leaf groups to level 1
    arb_if #(.N(L2_DIM))     l1_if ();    // Mid groups to root
    arb_if #(.N(1))          root_if ();  // Root request and enable

    // A pixel requests on either polarity
    for (genvar r = 0; r < `ARRAY_DIM; r++)
    begin : g_pix_row
        for (genvar c = 0; c < `ARRAY_DIM; c++)
        begin : g_pix_col
            assign pix_if.req[r][c] = |set_i[r][c];
        end
    end

    // Pixels hold no lock of their own
    assign pix_if.active      = 1'b0;
    assign pix_if.grp_release = 1'b0;

    assign root_if.gnt = root_if.req;  // Root enabled by its own request

    arbiter_level #(.N(`ARRAY_DIM)) level_0 (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .down     (l0_if.child),
        .up       (pix_if.parent),
        .x_bits_o (x_bits[0]),
        .y_bits_o (y_bits[0])
    );

    arbiter_level #(.N(L1_DIM)) level_1 (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .down     (l1_if.child),
        .up       (l0_if.parent),
        .x_bits_o (x_bits[1]),
        .y_bits_o (y_bits[1])
    );

    arbiter_level #(.N(L2_DIM)) level_2 (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .down     (root_if.child),
        .up       (l1_if.parent),
        .x_bits_o (x_bits[2]),
        .y_bits_o (y_bits[2])
    );

    assign x_addr  = x_bits;                  // Root bit is the MSB
    assign y_addr  = y_bits;
    assign pol_req = set_i[x_addr][y_addr];   // Granted pixel's polarity

    aer_encoder u_encoder (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .gnt_i         (pix_if.gnt),
        .x_i           (x_addr),
        .y_i           (y_addr),
        .pol_req_i     (pol_req),
        .event_valid_o (event_valid_o),
        .data_out_o    (event_word)
    );

    assign gnt_o         = pix_if.gnt;
    assign grp_release_o = root_if.grp_release;  // Whole array drained
    assign data_out_o    = event_word;

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock, starts low
module tb_clock #(
    parameter real PERIOD_NS = 8.0
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;  // Half period per toggle
    end

endmodule

`default_nettype wire

/* tests/pixel_hierarchy_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dvs_params.svh"

module pixel_hierarchy_tb
    import aer_pkg::*;
();

    localparam int DIM           = `ARRAY_DIM;
    localparam int QUAD          = DIM / 2;     // Pixels per side of a level-1 quadrant
    localparam int LEAF          = `GROUP_DIM;  // Pixels per side of a leaf group
    localparam int RANDOM_ROUNDS = 6;
    localparam int FULL_ROUNDS   = 4;           // Back to back, all pixels set
    localparam int ROUNDS        = RANDOM_ROUNDS + FULL_ROUNDS;
    localparam int IDLE_CYCLES   = 6;
    localparam int CLK_NS        = 8;
    localparam int WATCHDOG_NS   = (ROUNDS * 64 * 8 + ROUNDS * IDLE_CYCLES + 100) * CLK_NS;

    logic                                 clk_i;
    logic                                 reset_i;
    logic [DIM-1:0][DIM-1:0][`POL_W-1:0]  set_i;
    logic [DIM-1:0][DIM-1:0]              gnt_o;
    logic                                 grp_release_o;
    logic                                 event_valid_o;
    logic [$bits(aer_event_t)-1:0]        data_out_o;

    // Pixel model
    logic [DIM-1:0][DIM-1:0][`POL_W-1:0]  drive_set;  // Applied after the next edge
    bit                                   pending [DIM][DIM];
    logic [`POL_W-1:0]                    pol_model [DIM][DIM];
    int                                   pending_cnt;
    int                                   cycle_cnt;  // Zero in the reset release cycle
    bit                                   clear_due;
    int                                   clear_row;
    int                                   clear_col;
    bit                                   idle_phase;
    int                                   release_cnt;

    // Grant tracking
    logic [DIM-1:0][DIM-1:0]              prev_gnt;
    bit                                   prev_new_gnt;
    int                                   gnt_row;
    int                                   gnt_col;
    logic [`TS_W-1:0]                     gnt_ts;
    bit                                   have_cur;
    bit                                   quad_seen [2][2];
    int                                   quad_first [2][2];   // First leaf group this round
    int                                   last_first [2][2];
    bit                                   last_first_valid;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (
        .clk_o (clk_i)
    );

    pixel_hierarchy pixel_hierarchy_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .set_i         (set_i),
        .gnt_o         (gnt_o),
        .grp_release_o (grp_release_o),
        .event_valid_o (event_valid_o),
        .data_out_o    (data_out_o)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // Pending pixels inside a square block
    function automatic int pending_in(input int row0, input int col0, input int side);
        int n;
        n = 0;
        for (int r = row0; r < row0 + side; r++)
        begin
            for (int c = col0; c < col0 + side; c++)
                n += pending[r][c];
        end
        return n;
    endfunction

    // A new grant may leave a quadrant or leaf group only once it is drained
    task automatic check_locking(input int row, input int col);
        if (have_cur)
        begin
            if ((row / QUAD != gnt_row / QUAD || col / QUAD != gnt_col / QUAD) &&
                pending_in((gnt_row / QUAD) * QUAD, (gnt_col / QUAD) * QUAD, QUAD) != 0)
                report_failure($sformatf("grant left quadrant of pixel %0d,%0d with pixels pending",
                                         gnt_row, gnt_col));
            if ((row / LEAF != gnt_row / LEAF || col / LEAF != gnt_col / LEAF) &&
                pending_in((gnt_row / LEAF) * LEAF, (gnt_col / LEAF) * LEAF, LEAF) != 0)
                report_failure($sformatf("grant left leaf group of pixel %0d,%0d with pixels pending",
                                         gnt_row, gnt_col));
        end
        if (!quad_seen[row / QUAD][col / QUAD])
        begin
            quad_seen[row / QUAD][col / QUAD]  = 1'b1;
            quad_first[row / QUAD][col / QUAD] = ((row / LEAF) % 2) * 2 + (col / LEAF) % 2;
        end
    endtask

    // Sampled mid-cycle, after inputs and combinational grants settle
    task automatic observe_cycle();
        aer_event_t ev;
        polarity_e  exp_pol;
        bit         new_gnt;
        int         row;
        int         col;
        ev  = data_out_o;
        row = 0;
        col = 0;
        if ($countones(gnt_o) > 1)
            report_failure($sformatf("gnt_o holds more than one grant at %0t ns", $time));
        check_value("event_valid_o", prev_new_gnt, event_valid_o);  // One cycle after each grant
        if (event_valid_o)
        begin
            exp_pol = pol_model[gnt_row][gnt_col][0] ? ON : OFF;  // ON wins
            check_value("data_out_o.x", gnt_row, ev.x);
            check_value("data_out_o.y", gnt_col, ev.y);
            check_value("data_out_o.polarity", exp_pol, ev.polarity);
            check_value("data_out_o.timestamp", gnt_ts, ev.timestamp);
            pending[gnt_row][gnt_col] = 1'b0;
            pending_cnt--;
            clear_due = 1'b1;  // Pixel drops its request next cycle
            clear_row = gnt_row;
            clear_col = gnt_col;
        end
        if (grp_release_o)
        begin
            if (pending_cnt != 0)
                report_failure("grp_release_o pulsed while pixels were still pending");
            release_cnt++;
        end
        if (idle_phase)
            check_value("gnt_o", '0, gnt_o);
        new_gnt = (gnt_o != '0) && (gnt_o != prev_gnt);
        if (new_gnt)
        begin
            for (int r = 0; r < DIM; r++)
            begin
                for (int c = 0; c < DIM; c++)
                begin
                    if (gnt_o[r][c])
                    begin
                        row = r;
                        col = c;
                    end
                end
            end
            if (!pending[row][col])
                report_failure($sformatf("grant went to pixel %0d,%0d which is not pending",
                                         row, col));
            check_locking(row, col);
            have_cur = 1'b1;
            gnt_row  = row;
            gnt_col  = col;
            gnt_ts   = cycle_cnt[`TS_W-1:0];  // Counter in the grant cycle
        end
        prev_new_gnt = new_gnt;
        prev_gnt     = gnt_o;
    endtask

    task automatic step_cycle();
        @(posedge clk_i);
        cycle_cnt++;
        #1;
        if (clear_due)
        begin
            drive_set[clear_row][clear_col] = '0;
            clear_due = 1'b0;
        end
        set_i = drive_set;
        @(negedge clk_i);
        observe_cycle();
    endtask

    task automatic run_round(input bit full);
        int r;
        int c;
        pending_cnt = 0;
        for (r = 0; r < DIM; r++)
        begin
            for (c = 0; c < DIM; c++)
            begin
                pol_model[r][c] = (full || $urandom_range(0, 1)) ? 2'($urandom_range(1, 3)) : 2'b00;
                drive_set[r][c] = pol_model[r][c];
                pending[r][c]   = (pol_model[r][c] != 2'b00);
                pending_cnt    += pending[r][c];
            end
        end
        if (pending_cnt == 0)
        begin
            r = $urandom_range(0, DIM - 1);  // Never an empty round
            c = $urandom_range(0, DIM - 1);
            pol_model[r][c] = 2'b01;
            drive_set[r][c] = 2'b01;
            pending[r][c]   = 1'b1;
            pending_cnt     = 1;
        end
        quad_seen   = '{default: 1'b0};
        have_cur    = 1'b0;
        release_cnt = 0;
        idle_phase  = 1'b0;
        while (pending_cnt != 0 || release_cnt == 0)
            step_cycle();
        idle_phase = 1'b1;
        repeat (IDLE_CYCLES) step_cycle();
        check_value("grp_release_o pulse count", 1, release_cnt);
        if (full)
        begin
            for (r = 0; r < 2; r++)
            begin
                for (c = 0; c < 2; c++)
                begin
                    if (last_first_valid && quad_first[r][c] == last_first[r][c])
                        report_failure($sformatf("quadrant %0d,%0d started at leaf group %0d again",
                                                 r, c, quad_first[r][c]));
                    last_first[r][c] = quad_first[r][c];
                end
            end
            last_first_valid = 1'b1;
        end
    endtask

    initial
    begin
        void'($urandom(64));
        reset_i          = 1'b1;
        set_i            = '0;
        drive_set        = '0;
        prev_gnt         = '0;
        prev_new_gnt     = 1'b0;
        clear_due        = 1'b0;
        have_cur         = 1'b0;
        last_first_valid = 1'b0;
        pending          = '{default: 1'b0};
        pending_cnt      = 0;
        release_cnt      = 0;
        gnt_row          = 0;
        gnt_col          = 0;
        gnt_ts           = '0;
        cycle_cnt        = 0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i   = 1'b0;
        cycle_cnt = 0;
        idle_phase = 1'b1;  // Quiet array right after reset
        repeat (IDLE_CYCLES) step_cycle();
        check_value("grp_release_o pulse count", 0, release_cnt);
        for (int n = 0; n < ROUNDS; n++)
            run_round(n >= RANDOM_ROUNDS);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // Bounded by rounds x pixels x 8 cycles
    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the rounds did not drain within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hw/arb_pkg.sv
hw/aer_pkg.sv
hw/arb_if.sv
hw/group_arbiter.sv
hw/arbiter_level.sv
hw/aer_encoder.sv
hw/pixel_hierarchy.sv
tests/tb_clock.sv
tests/pixel_hierarchy_tb.sv
